//--- verilog/dnn_accel_defines.svh
// ======================================================================
// Fixed widths for the dot-product accelerator number format
// Operands are unsigned, four lanes, results never overflow 34 bits
// Buffer depth and counter widths must be changed together
// ======================================================================
`ifndef DNN_ACCEL_DEFINES_SVH
`define DNN_ACCEL_DEFINES_SVH

// Operand and lane count
`define DNN_ELEM_W      16
`define DNN_LANES       4

// Product and sum widths, one extra bit per adder level
`define DNN_PROD_W      32
`define DNN_PSUM_W      33
`define DNN_DOT_W       34

// Result buffer geometry
`define DNN_BUF_DEPTH   64
`define DNN_ADDR_W      6
// Wide enough to hold the full count of 64
`define DNN_CNT_W       7

`endif

//--- verilog/dnn_accel_pkg.sv
// ======================================================================
// Shared types for the dot-product accelerator
// Widths come from the defines header, so both must stay in step
// ======================================================================
`include "dnn_accel_defines.svh"

package dnn_accel_pkg;

    // Datapath words
    typedef logic [`DNN_ELEM_W-1:0] elem_t;
    typedef logic [`DNN_PROD_W-1:0] prod_t;
    typedef logic [`DNN_PSUM_W-1:0] psum_t;
    typedef logic [`DNN_DOT_W-1:0]  dot_t;

    // Result buffer addressing and counting
    typedef logic [`DNN_ADDR_W-1:0] buf_addr_t;
    typedef logic [`DNN_CNT_W-1:0]  buf_count_t;

    // Result buffer sequence
    typedef enum logic [1:0] {
        BUF_IDLE    = 2'b00,
        BUF_WRITING = 2'b01,
        BUF_FULL    = 2'b10,
        BUF_READING = 2'b11
    } buf_state_t;

endpackage

//--- verilog/dot_product_pipe.sv
// ======================================================================
// Four-lane unsigned dot product, fixed 7-cycle latency
// One operation per cycle, no stall, dot_valid follows each mac_take
// Payload registers carry no reset, only the valid chain is cleared
// ======================================================================
`timescale 1ns/1ps
`include "dnn_accel_defines.svh"

module dot_product_pipe
    import dnn_accel_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mac_take,
    input  elem_t a0,
    input  elem_t a1,
    input  elem_t a2,
    input  elem_t a3,
    input  elem_t b0,
    input  elem_t b1,
    input  elem_t b2,
    input  elem_t b3,
    output logic  dot_valid,
    output dot_t  dot_result
);

    // Multiplier is split on the B operand into two half-width rows
    localparam int HALF_W = `DNN_ELEM_W / 2;
    localparam int PP_W   = `DNN_ELEM_W + HALF_W;

    // ==================================================================
    // Stage 1: input register
    // ==================================================================
    elem_t a_q [`DNN_LANES];
    elem_t b_q [`DNN_LANES];
    logic  in_v;

    always_ff @(posedge clk) begin
        if (mac_take) begin
            a_q[0] <= a0;
            a_q[1] <= a1;
            a_q[2] <= a2;
            a_q[3] <= a3;
            b_q[0] <= b0;
            b_q[1] <= b1;
            b_q[2] <= b2;
            b_q[3] <= b3;
        end
    end

    // ==================================================================
    // Stages 2-4: lane multipliers and product capture
    // ==================================================================
    logic [PP_W-1:0] pp_lo [`DNN_LANES];
    logic [PP_W-1:0] pp_hi [`DNN_LANES];
    prod_t           mul_q [`DNN_LANES];
    prod_t           prod_q [`DNN_LANES];
    logic            pp_v;
    logic            mul_v;
    logic            prod_v;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DNN_LANES; i++) begin
            // Partial product rows for the low and high halves of B
            if (in_v) begin
                pp_lo[i] <= a_q[i] * b_q[i][HALF_W-1:0];
                pp_hi[i] <= a_q[i] * b_q[i][`DNN_ELEM_W-1:HALF_W];
            end
            // Recombine rows, high row weighted by 2^HALF_W
            if (pp_v) begin
                mul_q[i] <= {pp_hi[i], {HALF_W{1'b0}}} + {{HALF_W{1'b0}}, pp_lo[i]};
            end
            // Product capture ahead of the adder tree
            if (mul_v) begin
                prod_q[i] <= mul_q[i];
            end
        end
    end

    // ==================================================================
    // Stages 5-7: two-level adder tree
    // ==================================================================
    psum_t psum01;
    psum_t psum23;
    psum_t psum01_q;
    psum_t psum23_q;
    dot_t  dot_q;
    logic  psum_v;
    logic  psum_q_v;
    logic  dot_v;

    always_ff @(posedge clk) begin
        // First level, each sum one bit wider than a product
        if (prod_v) begin
            psum01 <= {1'b0, prod_q[0]} + {1'b0, prod_q[1]};
            psum23 <= {1'b0, prod_q[2]} + {1'b0, prod_q[3]};
        end
        // Timing register between the levels
        if (psum_v) begin
            psum01_q <= psum01;
            psum23_q <= psum23;
        end
        // Final level keeps the last carry
        if (psum_q_v) begin
            dot_q <= {1'b0, psum01_q} + {1'b0, psum23_q};
        end
    end

    // Valid chain, one bit per stage so several operations overlap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_v     <= 1'b0;
            pp_v     <= 1'b0;
            mul_v    <= 1'b0;
            prod_v   <= 1'b0;
            psum_v   <= 1'b0;
            psum_q_v <= 1'b0;
            dot_v    <= 1'b0;
        end else begin
            in_v     <= mac_take;
            pp_v     <= in_v;
            mul_v    <= pp_v;
            prod_v   <= mul_v;
            psum_v   <= prod_v;
            psum_q_v <= psum_v;
            dot_v    <= psum_q_v;
        end
    end

    assign dot_valid  = dot_v;
    assign dot_result = dot_q;

endmodule

//--- verilog/buffer_sequencer.sv
// ======================================================================
// Result buffer sequencer: idle, writing, full, reading
// A batch is exactly 64 accepted operations, extra EN_mac is dropped
// Read burst is 64 back-to-back cycles, memory latency assumed 1 cycle
// ======================================================================
`timescale 1ns/1ps
`include "dnn_accel_defines.svh"

module buffer_sequencer
    import dnn_accel_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en_mac,
    input  logic      en_block_read,
    input  logic      dot_valid,
    input  dot_t      dot_result,
    input  dot_t      read_mem_val,
    output logic      rdy_mac,
    output logic      mac_take,
    output logic      rdy_block_read,
    output logic      en_write_mem,
    output buf_addr_t write_mem_addr,
    output dot_t      write_mem_val,
    output logic      en_read_mem,
    output buf_addr_t read_mem_addr,
    output logic      valid_mem_val,
    output dot_t      mem_val_data
);

    localparam buf_count_t BATCH_SIZE = buf_count_t'(`DNN_BUF_DEPTH);
    localparam buf_count_t LAST_WRITE = buf_count_t'(`DNN_BUF_DEPTH - 1);
    localparam buf_addr_t  LAST_READ  = buf_addr_t'(`DNN_BUF_DEPTH - 1);

    buf_state_t state;
    buf_state_t state_nxt;
    buf_count_t accept_cnt;
    buf_count_t write_cnt;
    buf_addr_t  read_cnt;

    // ==================================================================
    // Accept side
    // ==================================================================
    // Ready until the batch has 64 operations in flight or written
    assign rdy_mac  = ((state == BUF_IDLE) || (state == BUF_WRITING)) &&
                      (accept_cnt < BATCH_SIZE);
    assign mac_take = en_mac && rdy_mac;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept_cnt <= '0;
        end else if (state == BUF_READING) begin
            // Batch is drained, next one starts from zero
            accept_cnt <= '0;
        end else if (mac_take) begin
            accept_cnt <= accept_cnt + 1'b1;
        end
    end

    // ==================================================================
    // Buffer state machine
    // ==================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            BUF_IDLE: begin
                if (mac_take) begin
                    state_nxt = BUF_WRITING;
                end
            end
            BUF_WRITING: begin
                // Full right after the 64th real write
                if (en_write_mem && (write_cnt == LAST_WRITE)) begin
                    state_nxt = BUF_FULL;
                end
            end
            BUF_FULL: begin
                if (en_block_read) begin
                    state_nxt = BUF_READING;
                end
            end
            BUF_READING: begin
                if (read_cnt == LAST_READ) begin
                    state_nxt = BUF_IDLE;
                end
            end
            default: begin
                state_nxt = BUF_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BUF_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign rdy_block_read = (state == BUF_FULL);

    // ==================================================================
    // Write side
    // ==================================================================
    // Results only land in the writing state, in arrival order
    assign en_write_mem   = dot_valid && (state == BUF_WRITING);
    assign write_mem_addr = write_cnt[`DNN_ADDR_W-1:0];
    assign write_mem_val  = dot_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_cnt <= '0;
        end else if (state == BUF_READING) begin
            write_cnt <= '0;
        end else if (en_write_mem) begin
            write_cnt <= write_cnt + 1'b1;
        end
    end

    // ==================================================================
    // Read side
    // ==================================================================
    // Every reading cycle issues one address, 0 to 63
    assign en_read_mem   = (state == BUF_READING);
    assign read_mem_addr = read_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_cnt <= '0;
        end else if (en_read_mem) begin
            // Wraps back to zero on the last address
            read_cnt <= read_cnt + 1'b1;
        end else begin
            read_cnt <= '0;
        end
    end

    // Valid lags the strobe by two: memory cycle plus output register
    logic rd_v;
    logic out_v;
    dot_t out_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_v  <= 1'b0;
            out_v <= 1'b0;
        end else begin
            rd_v  <= en_read_mem;
            out_v <= rd_v;
        end
    end

    // Memory word is on read_mem_val while rd_v is high
    always_ff @(posedge clk) begin
        if (rd_v) begin
            out_data <= read_mem_val;
        end
    end

    assign valid_mem_val = out_v;
    assign mem_val_data  = out_data;

endmodule

//--- verilog/dnn_accelerator.sv
// ======================================================================
// Dot-product accelerator top level
// Result memory is external: writes on en_write_mem, reads return
// read_mem_val one cycle after en_read_mem
// ======================================================================
`timescale 1ns/1ps

module dnn_accelerator
    import dnn_accel_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Operation input
    input  logic      en_mac,
    output logic      rdy_mac,
    input  elem_t     mac_vect_a0,
    input  elem_t     mac_vect_a1,
    input  elem_t     mac_vect_a2,
    input  elem_t     mac_vect_a3,
    input  elem_t     mac_vect_b0,
    input  elem_t     mac_vect_b1,
    input  elem_t     mac_vect_b2,
    input  elem_t     mac_vect_b3,
    // Result memory write port
    output logic      en_write_mem,
    output buf_addr_t write_mem_addr,
    output dot_t      write_mem_val,
    // Block read control
    input  logic      en_block_read,
    output logic      rdy_block_read,
    // Result memory read port
    output logic      en_read_mem,
    output buf_addr_t read_mem_addr,
    input  dot_t      read_mem_val,
    // Read-back stream
    output logic      valid_mem_val,
    output dot_t      mem_val_data
);

    logic mac_take;
    logic dot_valid;
    dot_t dot_result;

    // Datapath, accepts whatever the sequencer lets through
    dot_product_pipe u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .mac_take   (mac_take),
        .a0         (mac_vect_a0),
        .a1         (mac_vect_a1),
        .a2         (mac_vect_a2),
        .a3         (mac_vect_a3),
        .b0         (mac_vect_b0),
        .b1         (mac_vect_b1),
        .b2         (mac_vect_b2),
        .b3         (mac_vect_b3),
        .dot_valid  (dot_valid),
        .dot_result (dot_result)
    );

    // Batch control and memory strobes
    buffer_sequencer u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .en_mac         (en_mac),
        .en_block_read  (en_block_read),
        .dot_valid      (dot_valid),
        .dot_result     (dot_result),
        .read_mem_val   (read_mem_val),
        .rdy_mac        (rdy_mac),
        .mac_take       (mac_take),
        .rdy_block_read (rdy_block_read),
        .en_write_mem   (en_write_mem),
        .write_mem_addr (write_mem_addr),
        .write_mem_val  (write_mem_val),
        .en_read_mem    (en_read_mem),
        .read_mem_addr  (read_mem_addr),
        .valid_mem_val  (valid_mem_val),
        .mem_val_data   (mem_val_data)
    );

endmodule

//--- test/dot_checker.sv
// ======================================================================
// Port-level checker for the dot-product accelerator
// Samples on the rising edge, expects the 7-cycle pipe and 64-entry batches
// Directed operations carry their expected value from the stim file
// ======================================================================
`timescale 1ns/1ps
`include "dnn_accel_defines.svh"

module dot_checker
    import dnn_accel_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en_mac,
    input  logic      rdy_mac,
    input  elem_t     mac_vect_a0,
    input  elem_t     mac_vect_a1,
    input  elem_t     mac_vect_a2,
    input  elem_t     mac_vect_a3,
    input  elem_t     mac_vect_b0,
    input  elem_t     mac_vect_b1,
    input  elem_t     mac_vect_b2,
    input  elem_t     mac_vect_b3,
    input  logic      ref_known,
    input  dot_t      ref_dot,
    input  logic      en_write_mem,
    input  buf_addr_t write_mem_addr,
    input  dot_t      write_mem_val,
    input  logic      en_block_read,
    input  logic      rdy_block_read,
    input  logic      en_read_mem,
    input  buf_addr_t read_mem_addr,
    input  logic      valid_mem_val,
    input  dot_t      mem_val_data,
    output int        error_count,
    output int        check_count,
    output int        write_count,
    output int        read_count
);

    localparam int PIPE_LAT = 7;

    int        errors = 0;
    int        checks = 0;
    int        writes = 0;
    int        reads = 0;
    int        cyc = 0;
    int        rst_edges = 0;
    int        batch_acc = 0;
    int        wr_idx = 0;
    int        rd_idx = 0;
    logic      full_exp = 1'b0;
    logic      rd_active = 1'b0;
    // Two-stage history of the read strobe, lines up with valid_mem_val
    logic      rd_v1 = 1'b0;
    logic      rd_v2 = 1'b0;
    buf_addr_t rd_a1 = '0;
    buf_addr_t rd_a2 = '0;
    // Expected results in acceptance order, and the cycle of each accept
    dot_t      exp_q [$];
    int        acc_cyc_q [$];
    // Expected memory contents by address
    dot_t      shadow [`DNN_BUF_DEPTH];

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    always @(posedge clk) begin
        dot_t exp_val;
        int   acc_cyc;
        if (!rst_n) begin
            // Reset values of the control outputs
            // The first edge may be the one that applies the reset
            if (rst_edges > 0) begin
                check_value("rdy_mac", rdy_mac, 1);
                check_value("rdy_block_read", rdy_block_read, 0);
                check_value("en_write_mem", en_write_mem, 0);
                check_value("en_read_mem", en_read_mem, 0);
                check_value("valid_mem_val", valid_mem_val, 0);
            end
            rst_edges++;
        end else begin
            cyc++;
            // Ready flags follow the batch model
            check_value("rdy_mac", rdy_mac,
                        !full_exp && !rd_active && (batch_acc < `DNN_BUF_DEPTH));
            check_value("rdy_block_read", rdy_block_read, full_exp);

            // Read-back stream, two cycles behind each read strobe
            check_value("valid_mem_val", valid_mem_val, rd_v2);
            if (rd_v2 && valid_mem_val) begin
                check_value("mem_val_data", mem_val_data, shadow[rd_a2]);
                reads++;
            end
            rd_v2 = rd_v1;
            rd_a2 = rd_a1;
            rd_v1 = en_read_mem;
            rd_a1 = read_mem_addr;

            // Read burst of 64 back-to-back addresses
            if (rd_active) begin
                if (!en_read_mem) begin
                    note_failure("read strobe dropped inside the read burst");
                end else begin
                    check_value("read_mem_addr", read_mem_addr, rd_idx);
                end
                rd_idx++;
                if (rd_idx == `DNN_BUF_DEPTH) begin
                    rd_active = 1'b0;
                    batch_acc = 0;
                end
            end else if (en_read_mem) begin
                note_failure("read strobe outside a read burst");
            end
            if (en_block_read && rdy_block_read) begin
                rd_active = 1'b1;
                rd_idx    = 0;
                full_exp  = 1'b0;
            end

            // Result writes in acceptance order
            if (en_write_mem) begin
                if (exp_q.size() == 0) begin
                    note_failure("memory write with no accepted operation pending");
                end else begin
                    exp_val = exp_q.pop_front();
                    acc_cyc = acc_cyc_q.pop_front();
                    check_value("write_mem_val", write_mem_val, exp_val);
                    check_value("write_mem_addr", write_mem_addr, wr_idx);
                    check_value("en_write_mem latency", cyc - acc_cyc, PIPE_LAT);
                    shadow[wr_idx] = exp_val;
                    writes++;
                    wr_idx++;
                    if (wr_idx == `DNN_BUF_DEPTH) begin
                        wr_idx   = 0;
                        full_exp = 1'b1;
                    end
                end
            end

            // Accepted operation, expected value is the sum of lane products
            if (en_mac && rdy_mac) begin
                if (ref_known) begin
                    exp_val = ref_dot;
                end else begin
                    exp_val = dot_t'(mac_vect_a0) * dot_t'(mac_vect_b0) +
                              dot_t'(mac_vect_a1) * dot_t'(mac_vect_b1) +
                              dot_t'(mac_vect_a2) * dot_t'(mac_vect_b2) +
                              dot_t'(mac_vect_a3) * dot_t'(mac_vect_b3);
                end
                exp_q.push_back(exp_val);
                acc_cyc_q.push_back(cyc);
                batch_acc++;
            end
        end
    end

    assign error_count = errors;
    assign check_count = checks;
    assign write_count = writes;
    assign read_count  = reads;

endmodule

//--- test/tb_dnn_accelerator.sv
// ======================================================================
// Testbench for the dot-product accelerator, two full batches
// Run from the project root so that test/dnn_stim.hex is found
// First 16 operations of a batch come from the stim file, the rest random
// ======================================================================
`timescale 1ns/1ps
`include "dnn_accel_defines.svh"

module tb_dnn_accelerator
    import dnn_accel_pkg::*;
();

    localparam int RESET_CYCLES  = 10;
    localparam int DIRECTED      = 16;
    localparam int STIM_COLS     = 9;
    localparam int BATCHES       = 2;
    localparam int EXTRA_OFFERS  = 24;
    // Accepts, gap allowance, dropped offers, pipe, read burst, idle
    localparam int BATCH_CYCLES  = 64 + 32 + EXTRA_OFFERS + 8 + 64 + 8;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + BATCHES * BATCH_CYCLES);

    logic      clk;
    logic      rst_n;
    logic      en_mac;
    logic      en_block_read;
    elem_t     vec_a0, vec_a1, vec_a2, vec_a3;
    elem_t     vec_b0, vec_b1, vec_b2, vec_b3;
    logic      ref_known;
    dot_t      ref_dot;
    dot_t      read_mem_val;
    logic      rdy_mac, rdy_block_read, en_write_mem, en_read_mem, valid_mem_val;
    buf_addr_t write_mem_addr, read_mem_addr;
    dot_t      write_mem_val, mem_val_data;
    int        chk_errors, chk_checks, chk_writes, chk_reads;
    int        seed = 32'hb9d0_fa4d;
    logic [63:0] stim_mem [0:DIRECTED*STIM_COLS-1];
    dot_t      mem [`DNN_BUF_DEPTH];

    dnn_accelerator uut (
        .clk(clk), .rst_n(rst_n), .en_mac(en_mac), .rdy_mac(rdy_mac),
        .mac_vect_a0(vec_a0), .mac_vect_a1(vec_a1), .mac_vect_a2(vec_a2),
        .mac_vect_a3(vec_a3), .mac_vect_b0(vec_b0), .mac_vect_b1(vec_b1),
        .mac_vect_b2(vec_b2), .mac_vect_b3(vec_b3),
        .en_write_mem(en_write_mem), .write_mem_addr(write_mem_addr),
        .write_mem_val(write_mem_val), .en_block_read(en_block_read),
        .rdy_block_read(rdy_block_read), .en_read_mem(en_read_mem),
        .read_mem_addr(read_mem_addr), .read_mem_val(read_mem_val),
        .valid_mem_val(valid_mem_val), .mem_val_data(mem_val_data)
    );

    dot_checker chk (
        .clk(clk), .rst_n(rst_n), .en_mac(en_mac), .rdy_mac(rdy_mac),
        .mac_vect_a0(vec_a0), .mac_vect_a1(vec_a1), .mac_vect_a2(vec_a2),
        .mac_vect_a3(vec_a3), .mac_vect_b0(vec_b0), .mac_vect_b1(vec_b1),
        .mac_vect_b2(vec_b2), .mac_vect_b3(vec_b3),
        .ref_known(ref_known), .ref_dot(ref_dot),
        .en_write_mem(en_write_mem), .write_mem_addr(write_mem_addr),
        .write_mem_val(write_mem_val), .en_block_read(en_block_read),
        .rdy_block_read(rdy_block_read), .en_read_mem(en_read_mem),
        .read_mem_addr(read_mem_addr), .valid_mem_val(valid_mem_val),
        .mem_val_data(mem_val_data), .error_count(chk_errors),
        .check_count(chk_checks), .write_count(chk_writes), .read_count(chk_reads)
    );

    // 4 ns clock
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ==================================================================
    // Result memory model, one-cycle read latency
    // ==================================================================
    always @(posedge clk) begin
        if (en_write_mem) begin
            mem[write_mem_addr] <= write_mem_val;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_mem_val <= '0;
        end else if (en_read_mem) begin
            read_mem_val <= mem[read_mem_addr];
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    // Operands and expected value of one stim file line
    task automatic load_directed(input int idx);
        en_mac    <= 1'b1;
        vec_a0    <= elem_t'(stim_mem[idx*STIM_COLS + 0]);
        vec_a1    <= elem_t'(stim_mem[idx*STIM_COLS + 1]);
        vec_a2    <= elem_t'(stim_mem[idx*STIM_COLS + 2]);
        vec_a3    <= elem_t'(stim_mem[idx*STIM_COLS + 3]);
        vec_b0    <= elem_t'(stim_mem[idx*STIM_COLS + 4]);
        vec_b1    <= elem_t'(stim_mem[idx*STIM_COLS + 5]);
        vec_b2    <= elem_t'(stim_mem[idx*STIM_COLS + 6]);
        vec_b3    <= elem_t'(stim_mem[idx*STIM_COLS + 7]);
        ref_dot   <= dot_t'(stim_mem[idx*STIM_COLS + 8]);
        ref_known <= 1'b1;
    endtask

    task automatic load_random();
        en_mac    <= 1'b1;
        vec_a0    <= elem_t'($random(seed));
        vec_a1    <= elem_t'($random(seed));
        vec_a2    <= elem_t'($random(seed));
        vec_a3    <= elem_t'($random(seed));
        vec_b0    <= elem_t'($random(seed));
        vec_b1    <= elem_t'($random(seed));
        vec_b2    <= elem_t'($random(seed));
        vec_b3    <= elem_t'($random(seed));
        ref_known <= 1'b0;
    endtask

    // Offer operations until 64 are taken, then keep offering past the batch
    task automatic fill_batch();
        int taken;
        int extra;
        taken = 0;
        extra = 0;
        while (taken < `DNN_BUF_DEPTH || extra < EXTRA_OFFERS) begin
            @(posedge clk);
            if (en_mac && rdy_mac) begin
                taken++;
            end
            if (taken >= `DNN_BUF_DEPTH) begin
                extra++;
                load_random();
            end else if (($random(seed) & 7) == 0) begin
                // Idle gap
                en_mac <= 1'b0;
            end else if (taken < DIRECTED) begin
                load_directed(taken);
            end else begin
                load_random();
            end
        end
        en_mac <= 1'b0;
    endtask

    // Start a block read once full, then wait for all 64 values
    task automatic read_batch();
        int seen;
        seen = 0;
        while (!rdy_block_read) begin
            @(posedge clk);
        end
        en_block_read <= 1'b1;
        @(posedge clk);
        en_block_read <= 1'b0;
        while (seen < `DNN_BUF_DEPTH) begin
            @(posedge clk);
            if (valid_mem_val) begin
                seen++;
            end
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        int total;
        rst_n         = 1'b0;
        en_mac        = 1'b0;
        en_block_read = 1'b0;
        {vec_a0, vec_a1, vec_a2, vec_a3} = '0;
        {vec_b0, vec_b1, vec_b2, vec_b3} = '0;
        ref_known     = 1'b0;
        ref_dot       = '0;
        $readmemh("test/dnn_stim.hex", stim_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int b = 0; b < BATCHES; b++) begin
            fill_batch();
            read_batch();
        end
        total = chk_errors;
        if (chk_writes != BATCHES * `DNN_BUF_DEPTH) begin
            $display("ERROR wrong number of memory writes: %0d", chk_writes);
            total++;
        end
        if (chk_reads != BATCHES * `DNN_BUF_DEPTH) begin
            $display("ERROR wrong number of read-back values: %0d", chk_reads);
            total++;
        end
        $display("Checks: %0d  Errors: %0d", chk_checks, total);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- dnn_accelerator.f
+incdir+verilog
verilog/dnn_accel_pkg.sv
verilog/dot_product_pipe.sv
verilog/buffer_sequencer.sv
verilog/dnn_accelerator.sv
test/dot_checker.sv
test/tb_dnn_accelerator.sv

//--- Makefile
# Verilator build and run of the dot-product accelerator testbench
TOP := tb_dnn_accelerator

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run passes only when the pass line shows up in the output
test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f dnn_accelerator.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir

//--- test/dnn_stim.hex
// Columns: a0 a1 a2 a3 b0 b1 b2 b3 (16-bit hex), then the expected 34-bit dot product
// One directed operation per line, read in order at the start of every batch
0000 0000 0000 0000 0000 0000 0000 0000 000000000
ffff ffff ffff ffff ffff ffff ffff ffff 3fff80004
0001 0002 0003 0004 0005 0006 0007 0008 000000046
ffff 0000 0000 0000 ffff 0000 0000 0000 0fffe0001
0001 0001 0001 0001 0001 0001 0001 0001 000000004
ffff ffff ffff ffff 0000 0000 0000 0000 000000000
0100 0100 0100 0100 0100 0100 0100 0100 000040000
8000 8000 8000 8000 8000 8000 8000 8000 100000000
ffff ffff 0000 0000 ffff ffff 0000 0000 1fffc0002
0002 0003 0004 0005 0010 0010 0010 0010 0000000e0
1234 0000 0000 0000 0002 0000 0000 0000 000002468
0000 0000 0000 ffff 0000 0000 0000 0001 00000ffff
000a 000a 000a 000a 000a 000a 000a 000a 000000190
1000 2000 3000 4000 0001 0001 0001 0001 00000a000
ffff ffff ffff 0000 0001 0002 0003 0000 00005fffa
0000 0000 0000 0000 ffff ffff ffff ffff 000000000
